/* common/sdram_pkg.sv */
package sdram_pkg;

   typedef logic [1:0]  bank_t;
   typedef logic [12:0] row_t;
   typedef logic [8:0]  col_t;
   typedef logic [23:0] word_addr_t;   // bank on top, then row, then column.
   typedef logic [15:0] data_t;
   typedef logic [3:0]  cmd_t;         // packed as {csn, rasn, casn, wen}.

   localparam cmd_t CMD_NOP       = 4'b0111;
   localparam cmd_t CMD_ACTIVE    = 4'b0011;
   localparam cmd_t CMD_READ      = 4'b0101;
   localparam cmd_t CMD_WRITE     = 4'b0100;
   localparam cmd_t CMD_PRECHARGE = 4'b0010;
   localparam cmd_t CMD_REFRESH   = 4'b0001;
   localparam cmd_t CMD_LOAD_MODE = 4'b0000;

   // gaps are counted in clock cycles of NOP after the command.
   localparam int T_POWERUP        = 200;
   localparam int T_RP             = 2;
   localparam int T_RFC            = 7;
   localparam int T_MRD            = 2;
   localparam int T_RCD            = 2;
   localparam int CAS_LATENCY      = 2;
   localparam int T_WR             = 2;
   localparam int REFRESH_INTERVAL = 390;

   localparam logic [12:0] MODE_WORD      = 13'b0_0000_0010_0000; // cl 2, sequential, bl 1.
   localparam logic [12:0] ADDR_ALL_BANKS = 13'h0400;             // a10 high closes every bank.

   localparam int WAIT_W = $clog2(T_POWERUP);
   localparam int REF_W  = $clog2(REFRESH_INTERVAL);

   typedef logic [WAIT_W-1:0] wait_t;
   typedef logic [REF_W-1:0]  ref_cnt_t;

   localparam int         TEST_WORDS = 64;
   localparam int         TEST_IDX_W = $clog2(TEST_WORDS);
   localparam word_addr_t TEST_BASE  = 24'h41_2340;               // bank 1, away from row 0.

   typedef logic [TEST_IDX_W-1:0] test_idx_t;

   typedef enum logic [2:0] {
      INIT_WAIT,
      INIT_PRECHARGE,
      INIT_REFRESH1,
      INIT_REFRESH2,
      INIT_LOAD_MODE,
      INIT_DONE
   } init_state_t;

   typedef enum logic [3:0] {
      CTRL_INIT,
      CTRL_IDLE,
      CTRL_REFRESH,
      CTRL_ACTIVE,
      CTRL_READ,
      CTRL_WRITE,
      CTRL_PRECHARGE,
      CTRL_WAIT,
      CTRL_ACK
   } ctrl_state_t;

endpackage

/* common/mem_req_if.sv */
`timescale 1ns/10ps

interface mem_req_if
   import sdram_pkg::*;
();

   logic       req;     // stays high until ack is seen.
   logic       ack;     // stays high until req has dropped.
   logic       we;
   word_addr_t addr;
   data_t      wdata;
   data_t      rdata;   // valid while ack is high on a read.

   modport requester (
      output req, we, addr, wdata,
      input  ack, rdata
   );

   modport server (
      input  req, we, addr, wdata,
      output ack, rdata
   );

endinterface

/* sdram_ctrl/sdram_init.sv */
`timescale 1ns/10ps

module sdram_init
   import sdram_pkg::*;
(
   input  logic        clock,
   input  logic        rst_n,
   output cmd_t        init_cmd,
   output logic [12:0] init_addr,
   output logic        init_done
);

   init_state_t state;
   init_state_t after_wait;
   wait_t       wait_cnt;

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         state      <= INIT_WAIT;   // the power-up delay is the first wait.
         after_wait <= INIT_PRECHARGE;
         wait_cnt   <= wait_t'(T_POWERUP - 1);
      end else begin
         case (state)
            INIT_WAIT: begin
               if (wait_cnt == '0) begin
                  state <= after_wait;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            INIT_PRECHARGE: begin
               state      <= INIT_WAIT;
               after_wait <= INIT_REFRESH1;
               wait_cnt   <= wait_t'(T_RP - 1);
            end
            INIT_REFRESH1: begin
               state      <= INIT_WAIT;
               after_wait <= INIT_REFRESH2;
               wait_cnt   <= wait_t'(T_RFC - 1);
            end
            INIT_REFRESH2: begin
               state      <= INIT_WAIT;
               after_wait <= INIT_LOAD_MODE;
               wait_cnt   <= wait_t'(T_RFC - 1);
            end
            INIT_LOAD_MODE: begin
               state      <= INIT_WAIT;
               after_wait <= INIT_DONE;
               wait_cnt   <= wait_t'(T_MRD - 1);
            end
            default: state <= INIT_DONE;   // the sequence runs once per reset.
         endcase
      end
   end

   always_comb begin
      case (state)
         INIT_PRECHARGE: init_cmd = CMD_PRECHARGE;
         INIT_REFRESH1:  init_cmd = CMD_REFRESH;
         INIT_REFRESH2:  init_cmd = CMD_REFRESH;
         INIT_LOAD_MODE: init_cmd = CMD_LOAD_MODE;
         default:        init_cmd = CMD_NOP;
      endcase
   end

   assign init_addr = (state == INIT_LOAD_MODE) ? MODE_WORD :
                      (state == INIT_PRECHARGE) ? ADDR_ALL_BANKS : '0;
   assign init_done = (state == INIT_DONE);

   a_done_sticky: assert property (@(posedge clock) disable iff (!rst_n)
      init_done |=> init_done)
      else $error("sdram_init: init_done fell after the sequence had finished.");

endmodule

/* sdram_ctrl/sdram_ctrl.sv */
`timescale 1ns/10ps

module sdram_ctrl
   import sdram_pkg::*;
(
   input  logic        clock,
   input  logic        rst_n,
   mem_req_if.server   mem,
   output logic        init_done,
   output logic        cke,
   output cmd_t        cmd,
   output bank_t       ba,
   output logic [12:0] addr,
   output data_t       dq_out,
   output logic        dq_oe,
   output logic        dqs_out,
   output logic        dqs_oe,
   input  data_t       dq_in
);

   cmd_t                   init_cmd;
   logic [12:0]            init_addr;
   ctrl_state_t            state;
   ctrl_state_t            after_wait;
   wait_t                  wait_cnt;
   ref_cnt_t               ref_cnt;
   logic                   ref_wrap;
   logic                   ref_pending;
   logic                   accept;
   logic                   acc_we;
   bank_t                  acc_bank;
   row_t                   acc_row;
   col_t                   acc_col;
   logic [CAS_LATENCY-1:0] rd_pipe;
   data_t                  rdata_q;
   cmd_t                   ctrl_cmd;
   logic [12:0]            ctrl_addr;

   sdram_init init_i (
      .clock     (clock),
      .rst_n     (rst_n),
      .init_cmd  (init_cmd),
      .init_addr (init_addr),
      .init_done (init_done)
   );

   assign ref_wrap = (ref_cnt == ref_cnt_t'(REFRESH_INTERVAL - 1));

   // the interval runs freely, so a refresh held back by an access is not lost.
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         ref_cnt     <= '0;
         ref_pending <= 1'b0;
      end else if (init_done) begin
         ref_cnt <= ref_wrap ? '0 : ref_cnt + 1'b1;
         if (ref_wrap) begin
            ref_pending <= 1'b1;
         end else if (state == CTRL_REFRESH) begin
            ref_pending <= 1'b0;
         end
      end
   end

   assign accept = (state == CTRL_IDLE) && !ref_pending && mem.req;

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         state      <= CTRL_INIT;
         after_wait <= CTRL_IDLE;
         wait_cnt   <= '0;
         cke        <= 1'b0;
      end else begin
         cke <= 1'b1;
         case (state)
            CTRL_INIT: begin
               if (init_done) begin
                  state <= CTRL_IDLE;
               end
            end
            CTRL_IDLE: begin
               if (ref_pending) begin
                  state <= CTRL_REFRESH;   // refresh wins over a waiting request.
               end else if (mem.req) begin
                  state <= CTRL_ACTIVE;
               end
            end
            CTRL_REFRESH: begin
               state      <= CTRL_WAIT;
               after_wait <= CTRL_IDLE;
               wait_cnt   <= wait_t'(T_RFC - 1);
            end
            CTRL_ACTIVE: begin
               state      <= CTRL_WAIT;
               after_wait <= acc_we ? CTRL_WRITE : CTRL_READ;
               wait_cnt   <= wait_t'(T_RCD - 1);
            end
            CTRL_WRITE: begin
               state      <= CTRL_WAIT;
               after_wait <= CTRL_PRECHARGE;
               wait_cnt   <= wait_t'(T_WR - 1);
            end
            CTRL_READ: begin
               state      <= CTRL_WAIT;
               after_wait <= CTRL_PRECHARGE;
               wait_cnt   <= wait_t'(CAS_LATENCY - 1);   // data lands in the last cycle.
            end
            CTRL_PRECHARGE: begin
               state      <= CTRL_WAIT;
               after_wait <= CTRL_ACK;
               wait_cnt   <= wait_t'(T_RP - 1);
            end
            CTRL_WAIT: begin
               if (wait_cnt == '0) begin
                  state <= after_wait;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            CTRL_ACK: begin
               if (!mem.req) begin
                  state <= CTRL_IDLE;
               end
            end
            default: state <= CTRL_IDLE;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (accept) begin
         acc_we                       <= mem.we;
         {acc_bank, acc_row, acc_col} <= mem.addr;
         dq_out                       <= mem.wdata;
      end
      if (rd_pipe[CAS_LATENCY-1]) begin
         rdata_q <= dq_in;
      end
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         rd_pipe <= '0;
      end else begin
         rd_pipe <= (rd_pipe << 1) | CAS_LATENCY'(state == CTRL_READ);
      end
   end

   always_comb begin
      ctrl_cmd  = CMD_NOP;
      ctrl_addr = '0;
      ba        = '0;
      case (state)
         CTRL_REFRESH: ctrl_cmd = CMD_REFRESH;
         CTRL_ACTIVE: begin
            ctrl_cmd  = CMD_ACTIVE;
            ctrl_addr = acc_row;
            ba        = acc_bank;
         end
         CTRL_READ: begin
            ctrl_cmd  = CMD_READ;
            ctrl_addr = {4'b0000, acc_col};   // a10 low, no auto precharge.
            ba        = acc_bank;
         end
         CTRL_WRITE: begin
            ctrl_cmd  = CMD_WRITE;
            ctrl_addr = {4'b0000, acc_col};
            ba        = acc_bank;
         end
         CTRL_PRECHARGE: begin
            ctrl_cmd  = CMD_PRECHARGE;
            ctrl_addr = ADDR_ALL_BANKS;
         end
         default: ctrl_cmd = CMD_NOP;
      endcase
   end

   assign cmd       = init_done ? ctrl_cmd : init_cmd;
   assign addr      = init_done ? ctrl_addr : init_addr;
   assign dq_oe     = (state == CTRL_WRITE);
   assign dqs_out   = (state == CTRL_WRITE);   // a single strobe beat for burst length 1.
   assign dqs_oe    = (state == CTRL_WRITE);
   assign mem.ack   = (state == CTRL_ACK);
   assign mem.rdata = rdata_q;

   a_quiet_before_init: assert property (@(posedge clock) disable iff (!rst_n)
      !init_done |-> ctrl_cmd == CMD_NOP)
      else $error("sdram_ctrl: command issued while the power-up sequence was running.");

   a_ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
      $rose(mem.ack) |-> mem.req)
      else $error("sdram_ctrl: ack rose without a pending request.");

endmodule

/* verilog/mem_tester.sv */
`timescale 1ns/10ps

module mem_tester
   import sdram_pkg::*;
(
   input  logic         clock,
   input  logic         rst_n,
   input  logic         init_done,
   mem_req_if.requester mem,
   output logic [7:0]   leds
);

   typedef enum logic [1:0] {
      TST_IDLE,
      TST_REQ,
      TST_DROP
   } tst_state_t;

   tst_state_t state;
   test_idx_t  idx;
   logic       writing;
   logic       req_q;
   logic [7:0] pass_cnt;
   logic       pass_seen;
   logic       err;
   word_addr_t cur_addr;
   data_t      pattern;

   // the request fields only change while req is low.
   assign cur_addr  = TEST_BASE + word_addr_t'(idx);
   assign pattern   = cur_addr[15:0] ^ {pass_cnt, pass_cnt};
   assign mem.req   = req_q;
   assign mem.we    = writing;
   assign mem.addr  = cur_addr;
   assign mem.wdata = pattern;

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         state     <= TST_IDLE;
         idx       <= '0;
         writing   <= 1'b1;
         req_q     <= 1'b0;
         pass_cnt  <= '0;
         pass_seen <= 1'b0;
         err       <= 1'b0;
      end else begin
         case (state)
            TST_IDLE: begin
               if (init_done) begin
                  req_q <= 1'b1;
                  state <= TST_REQ;
               end
            end
            TST_REQ: begin
               if (mem.ack) begin
                  req_q <= 1'b0;
                  if (!writing && (mem.rdata != pattern)) begin
                     err <= 1'b1;   // stays set until the next reset.
                  end
                  state <= TST_DROP;
               end
            end
            TST_DROP: begin
               if (!mem.ack) begin
                  req_q <= 1'b1;
                  state <= TST_REQ;
                  if (idx == test_idx_t'(TEST_WORDS - 1)) begin
                     idx     <= '0;
                     writing <= !writing;
                     if (!writing) begin
                        pass_cnt  <= pass_cnt + 1'b1;
                        pass_seen <= 1'b1;
                     end
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            default: state <= TST_IDLE;
         endcase
      end
   end

   assign leds = {pass_cnt[4:0], err, pass_seen, init_done};

   a_req_after_ack_low: assert property (@(posedge clock) disable iff (!rst_n)
      $rose(mem.req) |-> !mem.ack)
      else $error("mem_tester: new request raised before ack was released.");

endmodule

/* verilog/big_sdram_fpga.sv */
`timescale 1ns/10ps

module big_sdram_fpga
   import sdram_pkg::*;
(
   input  logic        clock,
   input  logic        rst_n,
   output logic [7:0]  leds,
   output logic        ddr_clk,
   output logic        ddr_clkn,
   output logic        ddr_cke,
   output logic        ddr_csn,
   output logic        ddr_rasn,
   output logic        ddr_casn,
   output logic        ddr_wen,
   output logic [1:0]  ddr_ba,
   output logic [12:0] ddr_addr,
   output logic [1:0]  ddr_dm,
   output logic [15:0] ddr_dq_out,
   output logic        ddr_dq_oe,
   input  logic [15:0] ddr_dq_in,
   output logic [1:0]  ddr_dqs_out,
   output logic        ddr_dqs_oe
);

   logic init_done;
   cmd_t cmd;
   logic dqs_out;

   mem_req_if mem_bus ();

   mem_tester tester_i (
      .clock     (clock),
      .rst_n     (rst_n),
      .init_done (init_done),
      .mem       (mem_bus),
      .leds      (leds)
   );

   sdram_ctrl ctrl_i (
      .clock     (clock),
      .rst_n     (rst_n),
      .mem       (mem_bus),
      .init_done (init_done),
      .cke       (ddr_cke),
      .cmd       (cmd),
      .ba        (ddr_ba),
      .addr      (ddr_addr),
      .dq_out    (ddr_dq_out),
      .dq_oe     (ddr_dq_oe),
      .dqs_out   (dqs_out),
      .dqs_oe    (ddr_dqs_oe),
      .dq_in     (ddr_dq_in)
   );

   assign {ddr_csn, ddr_rasn, ddr_casn, ddr_wen} = cmd;
   assign ddr_dqs_out = {2{dqs_out}};   // both byte lanes strobe together.
   assign ddr_dm      = 2'b00;
   assign ddr_clk     = clock;
   assign ddr_clkn    = ~clock;

endmodule

/* testbench/sdram_model.sv */
`timescale 1ns/10ps

module sdram_model
   import sdram_pkg::*;
(
   input  logic        clock,
   input  logic        rst_n,
   input  cmd_t        cmd,
   input  bank_t       ba,
   input  logic [12:0] addr,
   input  data_t       dq,
   input  logic        dq_oe,
   output data_t       dq_in
);

   localparam int REFRESH_LIMIT = REFRESH_INTERVAL + 32;

   data_t      mem [word_addr_t];
   logic [3:0] open_bank;
   row_t       open_row [4];
   int         quiet_left;
   int         since_refresh;
   logic       init_seen;
   int         rd_cnt;
   data_t      rd_word;
   int         proto_errors = 0;

   function automatic data_t read_word(input word_addr_t a);
      return mem.exists(a) ? mem[a] : '0;   // unwritten words read as zero.
   endfunction

   task automatic corrupt_word(input word_addr_t a, input int bit_idx);
      data_t w;
      w = read_word(a);
      w[bit_idx] = ~w[bit_idx];
      mem[a] = w;
   endtask

   task automatic flag(input string msg);
      proto_errors++;
      $display("sdram model at %0t: %s", $time, msg);
   endtask

   always @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         open_bank     = '0;
         quiet_left    = 0;
         since_refresh = 0;
         init_seen     = 1'b0;
         rd_cnt        = 0;
         dq_in        <= '0;
      end else begin
         if (rd_cnt > 0) begin
            if (rd_cnt == 1) dq_in <= rd_word;   // valid at the cas latency edge.
            rd_cnt--;
         end
         if (init_seen) begin
            since_refresh++;
            if (since_refresh == REFRESH_LIMIT) flag("refresh missing for too long");
         end
         if (cmd == CMD_NOP) begin
            if (quiet_left > 0) quiet_left--;
         end else begin
            if (quiet_left > 0) flag("command issued inside a timing gap");
            case (cmd)
               CMD_ACTIVE: begin
                  open_bank[ba] = 1'b1;
                  open_row[ba]  = addr;
                  quiet_left    = T_RCD;
               end
               CMD_READ: begin
                  if (!open_bank[ba]) flag("read to a closed bank");
                  rd_word    = read_word({ba, open_row[ba], addr[8:0]});
                  rd_cnt     = CAS_LATENCY - 1;
                  quiet_left = CAS_LATENCY;
               end
               CMD_WRITE: begin
                  if (!open_bank[ba]) flag("write to a closed bank");
                  if (!dq_oe) flag("write without data output enable");
                  mem[{ba, open_row[ba], addr[8:0]}] = dq;
                  quiet_left = T_WR;
               end
               CMD_PRECHARGE: begin
                  if (addr[10]) open_bank = '0;
                  else open_bank[ba] = 1'b0;
                  quiet_left = T_RP;
               end
               CMD_REFRESH: begin
                  if (open_bank != '0) flag("refresh while a bank is open");
                  since_refresh = 0;
                  quiet_left    = T_RFC;
               end
               CMD_LOAD_MODE: begin
                  init_seen     = 1'b1;
                  since_refresh = 0;
                  quiet_left    = T_MRD;
               end
               default: flag("unknown command on the bus");
            endcase
         end
      end
   end

endmodule

/* testbench/tb_big_sdram.sv */
`timescale 1ns/10ps

module tb_big_sdram
   import sdram_pkg::*;
();

   localparam int ACCESS_MAX = T_RCD + CAS_LATENCY + T_RP + T_WR + 8;
   localparam int INIT_CYCLES = 16 + T_POWERUP + T_RP + 2 * T_RFC + T_MRD;
   localparam int WATCHDOG_CYCLES =
      INIT_CYCLES + 4 * (ACCESS_MAX + T_RFC + 1) * 2 * TEST_WORDS;

   logic        clock;
   logic        rst_n;
   logic [7:0]  leds;
   logic        ddr_clk;
   logic        ddr_clkn;
   logic        ddr_cke;
   logic        ddr_csn;
   logic        ddr_rasn;
   logic        ddr_casn;
   logic        ddr_wen;
   logic [1:0]  ddr_ba;
   logic [12:0] ddr_addr;
   logic [1:0]  ddr_dm;
   logic [15:0] ddr_dq_out;
   logic        ddr_dq_oe;
   logic [15:0] ddr_dq_in;
   logic [1:0]  ddr_dqs_out;
   logic        ddr_dqs_oe;
   cmd_t        obs_cmd;
   row_t        act_row [4];
   int          errors = 0;
   int          refresh_seen = 0;
   integer      seed = 32'hde4f_c9d4;

   big_sdram_fpga dut_i (.*);

   assign obs_cmd = {ddr_csn, ddr_rasn, ddr_casn, ddr_wen};

   sdram_model mem_i (
      .clock (clock),
      .rst_n (rst_n),
      .cmd   (obs_cmd),
      .ba    (ddr_ba),
      .addr  (ddr_addr),
      .dq    (ddr_dq_out),
      .dq_oe (ddr_dq_oe),
      .dq_in (ddr_dq_in)
   );

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   always @(negedge clock) begin
      if (obs_cmd == CMD_ACTIVE) act_row[ddr_ba] <= ddr_addr;   // row for later decode.
   end

   function automatic data_t expected_word(input word_addr_t a, input int pass);
      logic [7:0] p;
      p = pass[7:0];
      return a[15:0] ^ {p, p};
   endfunction

   task automatic check(input logic ok, input string msg);
      assert (ok) else begin
         errors++;
         $display("mismatch at %0t: %s", $time, msg);
      end
   endtask

   task automatic next_command(output int nops, output cmd_t c);
      nops = 0;
      @(negedge clock);
      while (obs_cmd == CMD_NOP) begin
         nops++;
         @(negedge clock);
      end
      c = obs_cmd;
   endtask

   task automatic wait_for_pass_count(input int n);
      while (leds[7:3] != 5'(n)) @(negedge clock);
   endtask

   task automatic wait_write_to(input word_addr_t target);
      forever begin
         @(negedge clock);
         if (obs_cmd == CMD_WRITE && {ddr_ba, act_row[ddr_ba], ddr_addr[8:0]} == target) break;
      end
   endtask

   task automatic check_reset_state;
      #2;
      check(ddr_clk && !ddr_clkn, "ddr clock pair wrong while the clock is high");
      @(negedge clock);
      #2;
      check(!ddr_clk && ddr_clkn, "ddr clock pair wrong while the clock is low");
      check(!ddr_cke && obs_cmd == CMD_NOP, "cke high or command issued during reset");
      check(!ddr_dq_oe && !ddr_dqs_oe, "data or strobe enable high during reset");
      check(leds == 8'h00, "leds not cleared during reset");
      check(ddr_dm == 2'b00, "data mask not zero during reset");
   endtask

   task automatic check_init_sequence;
      int   n;
      cmd_t c;
      next_command(n, c);
      check(n == T_POWERUP, $sformatf("power-up wait was %0d cycles", n));
      check(c == CMD_PRECHARGE && ddr_addr[10], "expected precharge-all after power-up");
      check(ddr_cke, "cke still low after the power-up wait");
      next_command(n, c);
      check(n == T_RP && c == CMD_REFRESH, "expected first refresh after t_rp");
      next_command(n, c);
      check(n == T_RFC && c == CMD_REFRESH, "expected second refresh after t_rfc");
      next_command(n, c);
      check(n == T_RFC && c == CMD_LOAD_MODE, "expected mode load after t_rfc");
      check(ddr_addr == MODE_WORD, $sformatf("mode word was %h", ddr_addr));
      repeat (T_MRD) begin
         @(negedge clock);
         check(obs_cmd == CMD_NOP && !leds[0], "init gap after mode load not quiet");
      end
      @(negedge clock);
      check(leds[0], "init led did not rise after the mode load gap");
   endtask

   task automatic check_first_pass_writes;
      int         seen;
      word_addr_t a;
      seen = 0;
      while (seen < TEST_WORDS) begin
         @(negedge clock);
         if (obs_cmd == CMD_WRITE) begin
            a = {ddr_ba, act_row[ddr_ba], ddr_addr[8:0]};
            check(a == TEST_BASE + word_addr_t'(seen),
                  $sformatf("write %0d went to address %h", seen, a));
            check(ddr_dq_out == expected_word(a, 0),
                  $sformatf("write data %h at address %h", ddr_dq_out, a));
            check(ddr_dq_oe && ddr_dqs_oe && ddr_dqs_out == 2'b11,
                  "data or strobe enable low in write");
            seen++;
         end else begin
            check(!ddr_dq_oe && !ddr_dqs_oe && ddr_dqs_out == 2'b00,
                  "data or strobe driven outside a write");
         end
         check(ddr_dm == 2'b00, "data mask not zero");
      end
   endtask

   task automatic check_clean_passes;
      int reads;
      reads = 0;
      // two passes are done once their reads are out and the next access opens a row.
      while (reads < 2 * TEST_WORDS) begin
         @(negedge clock);
         if (obs_cmd == CMD_READ) reads++;
      end
      while (obs_cmd != CMD_ACTIVE) @(negedge clock);
      check(leds[1], "pass led low after two passes");
      check(!leds[2], "error led set on clean passes");
      check(leds[7:3] == 5'd2, "pass count leds wrong");
      check(mem_i.proto_errors == 0, "memory model saw protocol errors");
   endtask

   task automatic monitor_refresh;
      int cycle;
      int last_ref;
      int rfc_left;
      cycle    = 0;
      last_ref = -1;
      rfc_left = 0;
      forever begin
         @(negedge clock);
         cycle++;
         if (obs_cmd == CMD_REFRESH) begin
            if (last_ref >= 0) begin
               check(cycle - last_ref <= REFRESH_INTERVAL + ACCESS_MAX,
                     $sformatf("refreshes %0d cycles apart", cycle - last_ref));
            end
            last_ref = cycle;
            rfc_left = T_RFC;
            refresh_seen++;
         end else if (rfc_left > 0) begin
            check(obs_cmd == CMD_NOP, "command inside the refresh gap");
            rfc_left--;
         end
      end
   endtask

   task automatic check_error_detection;
      int         idx;
      int         bit_idx;
      int         drops;
      word_addr_t target;
      idx     = {$random(seed)} % (TEST_WORDS / 2);
      bit_idx = {$random(seed)} % 16;
      target  = TEST_BASE + word_addr_t'(idx);
      wait_write_to(target);
      @(negedge clock);   // the model has stored the word by now.
      mem_i.corrupt_word(target, bit_idx);
      check(!leds[2], "error led set before the corrupted word was read");
      wait_for_pass_count(3);
      check(leds[2], "error led not set after the corrupted pass");
      drops = 0;
      while (leds[7:3] != 5'd4) begin
         @(negedge clock);
         if (!leds[2]) drops++;
      end
      check(drops == 0, "error led dropped during the following pass");
   endtask

   initial begin
      rst_n = 1'b0;
      repeat (15) @(posedge clock);
      check_reset_state();
      @(posedge clock);
      rst_n <= 1'b1;
      check_init_sequence();
      fork
         monitor_refresh();
      join_none
      check_first_pass_writes();
      check_clean_passes();
      check_error_detection();
      check(refresh_seen >= 2, "too few refreshes seen after init");
      $display("errors: %0d testbench, %0d memory model", errors, mem_i.proto_errors);
      if (errors + mem_i.proto_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * 8);
      $display("watchdog expired before the tests finished");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* list.f */
common/sdram_pkg.sv
common/mem_req_if.sv
sdram_ctrl/sdram_init.sv
sdram_ctrl/sdram_ctrl.sv
verilog/mem_tester.sv
verilog/big_sdram_fpga.sv
testbench/sdram_model.sv
testbench/tb_big_sdram.sv

/* Makefile */
TOP = tb_big_sdram
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f list.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
